/* pm_video_pkg.sv */
// Shared panel, raster and frame buffer sizes plus vector types for the LCD video path
package pm_video_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////////////////////////////////////////

    // One LCD column byte, eight vertical pixels, bit 0 on top
    typedef logic [7:0] column_t;
    typedef logic [9:0] fb_addr_t;
    typedef logic [1:0] bank_idx_t;
    typedef logic [7:0] scan_pos_t;
    typedef logic [2:0] row_bit_t;
    typedef logic [5:0] contrast_t;
    typedef logic [7:0] luma_t;

    ////////////////////////////////////////////////////////////////////////////
    // Panel and frame buffer
    ////////////////////////////////////////////////////////////////////////////

    localparam int LCD_XSIZE = 96;
    localparam int LCD_ROWS  = 8;
    localparam int FB_DEPTH  = LCD_XSIZE * LCD_ROWS;
    localparam int FB_BANKS  = 4;

    ////////////////////////////////////////////////////////////////////////////
    // Video raster
    ////////////////////////////////////////////////////////////////////////////

    localparam int H_TOTAL        = 140;
    localparam int V_TOTAL        = 119;
    localparam int H_ACTIVE_START = 16;
    localparam int V_ACTIVE_START = 32;

    // Horizontal sync window in pixels, vertical sync edges in lines
    localparam int HS_START = 120;
    localparam int HS_END   = 136;
    localparam int VS_START = 1;
    localparam int VS_END   = 4;

    localparam int PIX_CE_DIV    = 4;
    localparam int CONTRAST_FULL = 32;

endpackage

/* lcd_column_capture.sv */
// Accepts the LCD column byte stream and turns it into frame buffer writes over four banks
`timescale 1ns/1ps

module lcd_column_capture
(
    input  logic                   clk_sys,
    input  logic                   reset,
    input  logic                   col_valid,
    input  pm_video_pkg::column_t  col_data,
    output logic                   col_ready,
    output logic                   wr_en,
    output pm_video_pkg::bank_idx_t wr_bank,
    output pm_video_pkg::fb_addr_t wr_addr,
    output pm_video_pkg::column_t  wr_data
);

    localparam pm_video_pkg::fb_addr_t LAST_ADDR =
        pm_video_pkg::fb_addr_t'(pm_video_pkg::FB_DEPTH - 1);

    // Half-rate accept with ready on every other clock
    logic                    accept_phase;
    logic                    transfer;
    pm_video_pkg::fb_addr_t  addr_q;
    pm_video_pkg::bank_idx_t bank_q;

    assign col_ready = accept_phase;
    assign transfer  = col_valid & accept_phase;

    assign wr_en   = transfer;
    assign wr_bank = bank_q;
    assign wr_addr = addr_q;
    assign wr_data = col_data;

    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            accept_phase <= 1'b0;
            addr_q       <= '0;
            bank_q       <= '0;
        end
        else
        begin
            accept_phase <= ~accept_phase;

            if (transfer)
            begin
                // Frame done so the next one goes to the following bank (oldest frame)
                if (addr_q == LAST_ADDR)
                begin
                    addr_q <= '0;
                    bank_q <= bank_q + pm_video_pkg::bank_idx_t'(1);
                end
                else
                begin
                    addr_q <= addr_q + pm_video_pkg::fb_addr_t'(1);
                end
            end
        end
    end

endmodule

/* frame_history_ram.sv */
// Four frame buffers of column bytes, one write port and a shared registered read address
`timescale 1ns/1ps

module frame_history_ram
(
    input  logic                    clk_sys,
    input  logic                    wr_en,
    input  pm_video_pkg::bank_idx_t wr_bank,
    input  pm_video_pkg::fb_addr_t  wr_addr,
    input  pm_video_pkg::column_t   wr_data,
    input  pm_video_pkg::fb_addr_t  rd_addr,
    output pm_video_pkg::column_t   rd_data_0,
    output pm_video_pkg::column_t   rd_data_1,
    output pm_video_pkg::column_t   rd_data_2,
    output pm_video_pkg::column_t   rd_data_3
);

    pm_video_pkg::column_t rd_q [pm_video_pkg::FB_BANKS];

    // One block RAM per bank so all four can be read in the same clock
    for (genvar b = 0; b < pm_video_pkg::FB_BANKS; b++)
    begin : g_bank
        pm_video_pkg::column_t mem [pm_video_pkg::FB_DEPTH];

        always_ff @(posedge clk_sys)
        begin
            if (wr_en && (wr_bank == pm_video_pkg::bank_idx_t'(b)))
            begin
                mem[wr_addr] <= wr_data;
            end
            rd_q[b] <= mem[rd_addr];
        end
    end

    assign rd_data_0 = rd_q[0];
    assign rd_data_1 = rd_q[1];
    assign rd_data_2 = rd_q[2];
    assign rd_data_3 = rd_q[3];

endmodule

/* lcd_scan_timing.sv */
// Pixel enable, raster counters, syncs and frame buffer read address for the 140x119 raster
`timescale 1ns/1ps

module lcd_scan_timing
(
    input  logic                   clk_sys,
    input  logic                   reset,
    output logic                   pix_ce,
    output pm_video_pkg::fb_addr_t rd_addr,
    output pm_video_pkg::row_bit_t row_bit,
    output logic                   active,
    output logic                   hs,
    output logic                   vs
);

    localparam int CE_W         = $clog2(pm_video_pkg::PIX_CE_DIV);
    localparam int H_ACTIVE_END = pm_video_pkg::H_ACTIVE_START + pm_video_pkg::LCD_XSIZE;
    localparam int V_ACTIVE_END = pm_video_pkg::V_ACTIVE_START + pm_video_pkg::LCD_ROWS * 8;

    localparam pm_video_pkg::scan_pos_t H_LAST = pm_video_pkg::scan_pos_t'(pm_video_pkg::H_TOTAL - 1);
    localparam pm_video_pkg::scan_pos_t V_LAST = pm_video_pkg::scan_pos_t'(pm_video_pkg::V_TOTAL - 1);
    localparam pm_video_pkg::scan_pos_t X_LAST = pm_video_pkg::scan_pos_t'(pm_video_pkg::LCD_XSIZE - 1);
    localparam pm_video_pkg::scan_pos_t Y_LAST = pm_video_pkg::scan_pos_t'(pm_video_pkg::LCD_ROWS * 8 - 1);

    logic [CE_W-1:0]        ce_div;
    pm_video_pkg::scan_pos_t hpos;
    pm_video_pkg::scan_pos_t vpos;
    pm_video_pkg::scan_pos_t xpos;
    pm_video_pkg::scan_pos_t ypos;
    logic                   h_act;
    logic                   v_act;

    ////////////////////////////////////////////////////////////////////////////
    // Pixel enable
    ////////////////////////////////////////////////////////////////////////////

    assign pix_ce = (ce_div == CE_W'(pm_video_pkg::PIX_CE_DIV - 1));

    always_ff @(posedge clk_sys)
    begin
        if (reset)
            ce_div <= '0;
        else if (pix_ce)
            ce_div <= '0;
        else
            ce_div <= ce_div + CE_W'(1);
    end

    ////////////////////////////////////////////////////////////////////////////
    // Raster and panel counters
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            hpos <= '0;
            vpos <= '0;
            xpos <= '0;
            ypos <= '0;
        end
        else if (pix_ce)
        begin
            if (hpos == H_LAST)
            begin
                hpos <= '0;
                vpos <= (vpos == V_LAST) ? '0 : vpos + 8'd1;
                // Panel line advances only after a line that was shown
                if (v_act)
                    ypos <= (ypos == Y_LAST) ? '0 : ypos + 8'd1;
            end
            else
            begin
                hpos <= hpos + 8'd1;
            end

            if (h_act && v_act)
                xpos <= (xpos == X_LAST) ? '0 : xpos + 8'd1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Window, syncs and read address
    ////////////////////////////////////////////////////////////////////////////

    assign h_act  = (hpos >= 8'(pm_video_pkg::H_ACTIVE_START)) && (hpos < 8'(H_ACTIVE_END));
    assign v_act  = (vpos >= 8'(pm_video_pkg::V_ACTIVE_START)) && (vpos < 8'(V_ACTIVE_END));
    assign active = h_act & v_act;

    assign hs = (hpos >= 8'(pm_video_pkg::HS_START)) && (hpos < 8'(pm_video_pkg::HS_END));

    // Vertical sync edges fall at the horizontal sync start of their lines
    assign vs = ((vpos > 8'(pm_video_pkg::VS_START)) ||
                 ((vpos == 8'(pm_video_pkg::VS_START)) && (hpos >= 8'(pm_video_pkg::HS_START)))) &&
                ((vpos < 8'(pm_video_pkg::VS_END)) ||
                 ((vpos == 8'(pm_video_pkg::VS_END)) && (hpos < 8'(pm_video_pkg::HS_START))));

    assign rd_addr = pm_video_pkg::fb_addr_t'(ypos >> 3) *
                     pm_video_pkg::fb_addr_t'(pm_video_pkg::LCD_XSIZE) +
                     pm_video_pkg::fb_addr_t'(xpos);
    assign row_bit = ypos[2:0];

endmodule

/* grey_shade_mixer.sv */
// Blends the four stored frames into one grey level scaled by contrast, with aligned syncs
`timescale 1ns/1ps

module grey_shade_mixer
(
    input  logic                   clk_sys,
    input  logic                   reset,
    input  logic                   pix_ce,
    input  pm_video_pkg::row_bit_t row_bit,
    input  logic                   active,
    input  logic                   hs,
    input  logic                   vs,
    input  pm_video_pkg::contrast_t contrast,
    input  pm_video_pkg::column_t  rd_data_0,
    input  pm_video_pkg::column_t  rd_data_1,
    input  pm_video_pkg::column_t  rd_data_2,
    input  pm_video_pkg::column_t  rd_data_3,
    output pm_video_pkg::luma_t    video_luma,
    output logic                   video_de,
    output logic                   video_hs,
    output logic                   video_vs
);

    pm_video_pkg::luma_t lit_level;
    logic [9:0]          shade_sum;
    pm_video_pkg::luma_t grey;

    // A cleared bit is a dark (lit) LCD pixel
    function automatic logic [9:0] lit_term(
        input pm_video_pkg::column_t  col,
        input pm_video_pkg::row_bit_t bit_sel,
        input pm_video_pkg::luma_t    level
    );
        lit_term = col[bit_sel] ? 10'd0 : {2'b00, level};
    endfunction

    assign lit_level = (contrast >= pm_video_pkg::contrast_t'(pm_video_pkg::CONTRAST_FULL)) ?
                       8'd255 : {contrast[4:0], 3'b000};

    assign shade_sum = lit_term(rd_data_0, row_bit, lit_level) +
                       lit_term(rd_data_1, row_bit, lit_level) +
                       lit_term(rd_data_2, row_bit, lit_level) +
                       lit_term(rd_data_3, row_bit, lit_level);

    // Average over the four frames
    assign grey = active ? shade_sum[9:2] : '0;

    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            video_luma <= '0;
            video_de   <= 1'b0;
            video_hs   <= 1'b0;
            video_vs   <= 1'b0;
        end
        else if (pix_ce)
        begin
            video_luma <= grey;
            video_de   <= active;
            video_hs   <= hs;
            video_vs   <= vs;
        end
    end

endmodule

/* pm_lcd_video.sv */
// Top of the LCD video path, from column byte stream in to grey video raster out
`timescale 1ns/1ps

module pm_lcd_video
(
    input  logic                    clk_sys,
    input  logic                    reset,
    input  logic                    col_valid,
    input  pm_video_pkg::column_t   col_data,
    output logic                    col_ready,
    input  pm_video_pkg::contrast_t contrast,
    output logic                    video_ce,
    output pm_video_pkg::luma_t     video_luma,
    output logic                    video_de,
    output logic                    video_hs,
    output logic                    video_vs
);

    logic                    wr_en;
    pm_video_pkg::bank_idx_t wr_bank;
    pm_video_pkg::fb_addr_t  wr_addr;
    pm_video_pkg::column_t   wr_data;
    pm_video_pkg::fb_addr_t  rd_addr;
    pm_video_pkg::column_t   rd_data_0;
    pm_video_pkg::column_t   rd_data_1;
    pm_video_pkg::column_t   rd_data_2;
    pm_video_pkg::column_t   rd_data_3;
    logic                    pix_ce;
    pm_video_pkg::row_bit_t  row_bit;
    logic                    active;
    logic                    hs;
    logic                    vs;

    lcd_column_capture capture_i
    (
        .clk_sys   (clk_sys),
        .reset     (reset),
        .col_valid (col_valid),
        .col_data  (col_data),
        .col_ready (col_ready),
        .wr_en     (wr_en),
        .wr_bank   (wr_bank),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    frame_history_ram history_i
    (
        .clk_sys   (clk_sys),
        .wr_en     (wr_en),
        .wr_bank   (wr_bank),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_addr   (rd_addr),
        .rd_data_0 (rd_data_0),
        .rd_data_1 (rd_data_1),
        .rd_data_2 (rd_data_2),
        .rd_data_3 (rd_data_3)
    );

    lcd_scan_timing timing_i
    (
        .clk_sys (clk_sys),
        .reset   (reset),
        .pix_ce  (pix_ce),
        .rd_addr (rd_addr),
        .row_bit (row_bit),
        .active  (active),
        .hs      (hs),
        .vs      (vs)
    );

    grey_shade_mixer mixer_i
    (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .pix_ce     (pix_ce),
        .row_bit    (row_bit),
        .active     (active),
        .hs         (hs),
        .vs         (vs),
        .contrast   (contrast),
        .rd_data_0  (rd_data_0),
        .rd_data_1  (rd_data_1),
        .rd_data_2  (rd_data_2),
        .rd_data_3  (rd_data_3),
        .video_luma (video_luma),
        .video_de   (video_de),
        .video_hs   (video_hs),
        .video_vs   (video_vs)
    );

    assign video_ce = pix_ce;

endmodule

/* tb_pm_lcd_video.sv */
// Testbench for the LCD video top that runs the commands of pm_video_stim.txt against the DUT
`timescale 1ns/1ps

module tb_pm_lcd_video;

    logic                    clk_sys;
    logic                    reset;
    logic                    col_valid;
    pm_video_pkg::column_t   col_data;
    logic                    col_ready;
    pm_video_pkg::contrast_t contrast;
    logic                    video_ce;
    pm_video_pkg::luma_t     video_luma;
    logic                    video_de;
    logic                    video_hs;
    logic                    video_vs;

    int    checks;
    int    mismatches;
    int    other_errors;
    int    cycle_count;
    int    cycle_limit;
    string cmd_lines[$];

    pm_lcd_video dut_i
    (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .col_valid  (col_valid),
        .col_data   (col_data),
        .col_ready  (col_ready),
        .contrast   (contrast),
        .video_ce   (video_ce),
        .video_luma (video_luma),
        .video_de   (video_de),
        .video_hs   (video_hs),
        .video_vs   (video_vs)
    );

    initial
    begin
        clk_sys = 1'b0;
        forever #4 clk_sys = ~clk_sys;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic step_cycle();
        begin
            @(posedge clk_sys);
            #1;
        end
    endtask

    task automatic compare_value(input string name, input int got, input int exp);
        begin
            checks++;
            if (got != exp)
            begin
                mismatches++;
                $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            end
        end
    endtask

    // Even columns carry the pattern, odd columns its inverse
    task automatic send_frame(input pm_video_pkg::column_t pattern);
        int gap;
        begin
            for (int addr = 0; addr < pm_video_pkg::FB_DEPTH; addr++)
            begin
                col_valid = 1'b1;
                col_data  = ((addr % pm_video_pkg::LCD_XSIZE) % 2 == 0) ? pattern : ~pattern;
                while (!col_ready)
                    step_cycle();
                step_cycle();
                col_valid = 1'b0;
                gap = $urandom_range(3, 0);
                repeat (gap)
                    step_cycle();
            end
        end
    endtask

    // Sampled on the falling edge so each video pixel is seen once with video_ce high
    task automatic check_pixel(input int x, input int y, input int e);
        logic vs_last;
        int   idx;
        int   target;
        bit   done;
        begin
            target = y * pm_video_pkg::LCD_XSIZE + x;
            idx    = 0;
            done   = 1'b0;
            @(negedge clk_sys);
            vs_last = video_vs;
            @(negedge clk_sys);
            while (!(video_vs && !vs_last))
            begin
                vs_last = video_vs;
                @(negedge clk_sys);
            end
            while (!done)
            begin
                @(negedge clk_sys);
                if (video_ce && video_de)
                begin
                    if (idx == target)
                    begin
                        done = 1'b1;
                        checks++;
                        if (int'(video_luma) != e)
                        begin
                            mismatches++;
                            $display("Mismatch at %0t: video_luma at (%0d,%0d) got %0d expected %0d",
                                     $time, x, y, video_luma, e);
                        end
                    end
                    idx++;
                end
            end
            step_cycle();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        int    fd;
        int    f_count;
        int    p_count;
        int    a;
        int    b;
        int    c;
        byte   cmd;
        string line;
        string rest;

        reset        = 1'b1;
        col_valid    = 1'b0;
        col_data     = '0;
        contrast     = '0;
        checks       = 0;
        mismatches   = 0;
        other_errors = 0;
        f_count      = 0;
        p_count      = 0;
        void'($urandom(32'hb14c_5686));

        fd = $fopen("pm_video_stim.txt", "r");
        if (fd == 0)
        begin
            other_errors++;
            $display("Could not open the stimulus file pm_video_stim.txt");
        end
        else
        begin
            while (!$feof(fd))
            begin
                if ($fgets(line, fd) != 0)
                begin
                    cmd_lines.push_back(line);
                    if (line.getc(0) == "F")
                        f_count++;
                    if (line.getc(0) == "P")
                        p_count++;
                end
            end
            $fclose(fd);
        end

        // Budget per pixel check and per frame sent
        cycle_limit = 80000 * p_count + 4000 * f_count;

        repeat (10)
            @(posedge clk_sys);
        #1;
        reset = 1'b0;

        // Outputs idle after reset while ready toggles starting low
        // and the pixel enable pulses once every four clocks
        for (int i = 0; i < 8; i++)
        begin
            @(negedge clk_sys);
            if (i == 0)
            begin
                compare_value("video_de", int'(video_de), 0);
                compare_value("video_hs", int'(video_hs), 0);
                compare_value("video_vs", int'(video_vs), 0);
                compare_value("video_luma", int'(video_luma), 0);
            end
            compare_value("col_ready", int'(col_ready), i % 2);
            compare_value("video_ce", int'(video_ce), (i % 4 == 3) ? 1 : 0);
        end
        step_cycle();

        foreach (cmd_lines[i])
        begin
            line = cmd_lines[i];
            cmd  = line.getc(0);
            rest = line.substr(1, line.len() - 1);
            case (cmd)
                "F":
                begin
                    if ($sscanf(rest, "%h", a) != 1)
                    begin
                        other_errors++;
                        $display("Malformed frame command in stimulus line %0d", i + 1);
                    end
                    else
                        send_frame(a[7:0]);
                end
                "C":
                begin
                    if ($sscanf(rest, "%d", a) != 1)
                    begin
                        other_errors++;
                        $display("Malformed contrast command in stimulus line %0d", i + 1);
                    end
                    else
                    begin
                        contrast = a[5:0];
                        step_cycle();
                    end
                end
                "P":
                begin
                    if ($sscanf(rest, "%d %d %d", a, b, c) != 3)
                    begin
                        other_errors++;
                        $display("Malformed pixel command in stimulus line %0d", i + 1);
                    end
                    else
                        check_pixel(a, b, c);
                end
                "#", " ", "\n", "\r":
                begin
                end
                default:
                begin
                    other_errors++;
                    $display("Unknown command in stimulus line %0d", i + 1);
                end
            endcase
        end

        $display("Done: %0d checks, %0d mismatches, %0d other errors",
                 checks, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

    // Watchdog
    initial
    begin
        cycle_count = 0;
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit)
        begin
            @(posedge clk_sys);
            cycle_count++;
        end
        other_errors++;
        $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
        $display("Done: %0d checks, %0d mismatches, %0d other errors",
                 checks, mismatches, other_errors);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* pm_video_stim.txt */
# F pp: send a frame of column byte pp in hex, inverted at odd x | C c: contrast, decimal
# P x y e: check video_luma at panel pixel (x, y) against e, all decimal
C 40
F 00
F 00
F 00
F 00
P 0 0 255
P 1 0 0
P 95 63 0
P 94 63 255
F FF
F FF
P 2 5 127
P 3 20 127
F FF
P 6 11 63
P 7 11 191
F 00
F 00
F 00
F 00
C 12
P 8 8 96
C 32
P 8 8 255
F 0F
F 0F
F 0F
F 0F
C 40
P 4 2 0
P 4 6 255
P 51 33 255

/* verilog.f */
pm_video_pkg.sv
lcd_column_capture.sv
frame_history_ram.sv
lcd_scan_timing.sv
grey_shade_mixer.sv
pm_lcd_video.sv
tb_pm_lcd_video.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_pm_lcd_video
FILELIST  = verilog.f
PASS_MSG  = PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
